/* Bender.yml */
package:
  name: uart_to_display

sources:
  - include_dirs:
      - include
    files:
      - verilog/isa_pkg.sv
      - verilog/display_pkg.sv
      - verilog/stack_if.sv
      - verilog/uart_receiver.sv
      - verilog/exec_core.sv
      - verilog/stack_ram.sv
      - verilog/seg_scanner.sv
      - verilog/uart_to_display.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/uart_to_display_props.sv
      - tests/uart_to_display_tb.sv

/* filelist.f */
+incdir+include
verilog/isa_pkg.sv
verilog/display_pkg.sv
verilog/stack_if.sv
verilog/uart_receiver.sv
verilog/exec_core.sv
verilog/stack_ram.sv
verilog/seg_scanner.sv
verilog/uart_to_display.sv
tests/uart_to_display_props.sv
tests/uart_to_display_tb.sv

/* include/uart_to_display_consts.svh */
`ifndef UART_TO_DISPLAY_CONSTS_SVH
`define UART_TO_DISPLAY_CONSTS_SVH

// System clock
`define CLK_FREQ_HZ 100000000

// Serial line rate
`define BAUD_RATE 115200

// Clocks per UART bit, rounds down to 868
`define CLKS_PER_BIT (`CLK_FREQ_HZ / `BAUD_RATE)

// On-chip stack size in words
`define STACK_DEPTH 256

// Stack word address width
`define STACK_AW 8

// General purpose registers r0..r15
`define NUM_REGS 16

// Register shown on the seven-segment display
`define DISPLAY_REG 3

// Cycles each digit stays selected
`define SCAN_CYCLES 256

// Digits on the display
`define NUM_DIGITS 4

`endif

/* tests/uart_to_display_props.sv */
`timescale 1ns/10ps

module uart_to_display_props (
    input logic                    clk_100mhz,
    input logic                    rst_n,
    input display_pkg::digit_sel_t seg_sel,
    input logic                    stack_req,
    input logic                    stack_done,
    input logic                    rx_data_ready
);

    // Exactly one digit driven
    sel_one_low: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        $onehot(~seg_sel))
        else $error("seg_sel does not have exactly one bit low");

    // Stack RAM answers one cycle after the request
    done_after_req: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        stack_req |=> stack_done)
        else $error("stack done missing one cycle after req");

    done_only_after_req: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        stack_done |-> $past(stack_req))
        else $error("stack done without a req in the previous cycle");

    // Single-cycle strobe
    req_single_cycle: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        stack_req |=> !stack_req)
        else $error("stack req high for two cycles in a row");

    // Receiver stalled while an operation is outstanding
    ready_low_in_stack_op: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        (stack_req || stack_done) |-> !rx_data_ready)
        else $error("rx_data_ready high during a stack operation");

endmodule

bind uart_to_display uart_to_display_props uart_to_display_props_inst (
    .clk_100mhz    (clk_100mhz),
    .rst_n         (rst_n),
    .seg_sel       (seg_sel),
    .stack_req     (stack_bus.req),
    .stack_done    (stack_bus.done),
    .rx_data_ready (rx_data_ready)
);

/* tests/uart_to_display_tb.sv */
`timescale 1ns/10ps
`include "uart_to_display_consts.svh"

module uart_to_display_tb;

    // Instruction and display-check counts over all tests
    localparam longint NUM_INSTRS = 328;
    localparam longint NUM_CHECKS = 65;
    localparam longint INSTR_CYCLES = 2 * 10 * `CLKS_PER_BIT + 8;
    // Settle time plus one full rotation per display check
    localparam longint CHECK_CYCLES = (2 * `NUM_DIGITS + 1) * `SCAN_CYCLES;
    localparam longint WALK_CYCLES = `NUM_DIGITS * `SCAN_CYCLES;
    // 20% margin on top
    localparam longint TIMEOUT_CYCLES =
        (NUM_INSTRS * INSTR_CYCLES + NUM_CHECKS * CHECK_CYCLES + WALK_CYCLES) * 12 / 10;

    // Active-low select per digit, leftmost first
    localparam display_pkg::digit_sel_t SEL_ORDER [`NUM_DIGITS] = '{
        4'b1110, 4'b1101, 4'b1011, 4'b0111
    };

    logic                    clk_100mhz;
    logic                    rst_n;
    logic                    uart_rx;
    display_pkg::digit_sel_t seg_sel;
    display_pkg::seg_t       seg_data;

    // Reference model of the architectural state
    isa_pkg::word_t model_regs [`NUM_REGS];
    isa_pkg::word_t model_stack [`STACK_DEPTH];
    logic [`STACK_AW-1:0] model_sp;

    int unsigned lcg_state = 20;
    longint cycle_count = 0;

    uart_to_display uart_to_display_inst (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .uart_rx    (uart_rx),
        .seg_sel    (seg_sel),
        .seg_data   (seg_data)
    );

    initial clk_100mhz = 1'b0;
    always #5 clk_100mhz = ~clk_100mhz;

    task automatic end_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Run limit
    always @(posedge clk_100mhz) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_segments(input string name, input display_pkg::seg_t exp,
                                  input display_pkg::seg_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_select(input string name, input display_pkg::digit_sel_t exp,
                                input display_pkg::digit_sel_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // LCG, upper half of the state is used
    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Nonzero immediate so every ADDI changes the target
    function automatic logic [3:0] pick_imm();
        return 4'((next_random() % 15) + 1);
    endfunction

    // Any register other than the displayed one
    function automatic isa_pkg::reg_idx_t pick_reg();
        isa_pkg::reg_idx_t idx;
        idx = 4'(next_random() % 16);
        if (idx == `DISPLAY_REG) begin
            idx = 4'd4;
        end
        return idx;
    endfunction

    // [Op:2][Mod:6][Src:4][Dst:4]
    function automatic isa_pkg::word_t encode(input logic [1:0] op, input logic [5:0] mod,
                                              input logic [3:0] src, input logic [3:0] dst);
        return {op, mod, src, dst};
    endfunction

    // Reset also clears the model, stack RAM contents survive
    task automatic apply_reset();
        @(negedge clk_100mhz);
        rst_n = 1'b0;
        repeat (5) @(negedge clk_100mhz);
        rst_n = 1'b1;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        model_sp = '0;
    endtask

    // 8N1 frame, LSB first
    task automatic send_byte(input logic [7:0] value);
        uart_rx = 1'b0;
        repeat (`CLKS_PER_BIT) @(negedge clk_100mhz);
        for (int i = 0; i < 8; i++) begin
            uart_rx = value[i];
            repeat (`CLKS_PER_BIT) @(negedge clk_100mhz);
        end
        uart_rx = 1'b1;
        repeat (`CLKS_PER_BIT) @(negedge clk_100mhz);
    endtask

    // High byte first
    task automatic send_instr(input isa_pkg::word_t word);
        send_byte(word[15:8]);
        send_byte(word[7:0]);
        repeat (8) @(negedge clk_100mhz);
    endtask

    task automatic mov_reg(input isa_pkg::reg_idx_t dst, input isa_pkg::reg_idx_t src);
        send_instr(encode(isa_pkg::R_FAMILY, isa_pkg::MOD_MOV, src, dst));
        model_regs[dst] = model_regs[src];
    endtask

    task automatic add_reg(input isa_pkg::reg_idx_t dst, input isa_pkg::reg_idx_t src);
        send_instr(encode(isa_pkg::R_FAMILY, isa_pkg::MOD_ADD, src, dst));
        model_regs[dst] = model_regs[dst] + model_regs[src];
    endtask

    task automatic xor_reg(input isa_pkg::reg_idx_t dst, input isa_pkg::reg_idx_t src);
        send_instr(encode(isa_pkg::R_FAMILY, isa_pkg::MOD_XOR, src, dst));
        model_regs[dst] = model_regs[dst] ^ model_regs[src];
    endtask

    task automatic addi_reg(input isa_pkg::reg_idx_t dst, input logic [3:0] imm);
        send_instr(encode(isa_pkg::R_FAMILY, isa_pkg::MOD_ADDI, imm, dst));
        model_regs[dst] = model_regs[dst] + {12'h000, imm};
    endtask

    task automatic push_reg(input isa_pkg::reg_idx_t dst);
        send_instr(encode(isa_pkg::M_FAMILY, isa_pkg::MOD_PUSH, 4'h0, dst));
        model_stack[model_sp] = model_regs[dst];
        model_sp = model_sp + 1'b1;
    endtask

    task automatic pop_reg(input isa_pkg::reg_idx_t dst);
        send_instr(encode(isa_pkg::M_FAMILY, isa_pkg::MOD_POP, 4'h0, dst));
        model_sp = model_sp - 1'b1;
        model_regs[dst] = model_stack[model_sp];
    endtask

    // Targets r3, model stays as it is
    task automatic send_inert(input logic [1:0] op, input logic [5:0] mod,
                              input isa_pkg::reg_idx_t src);
        send_instr(encode(op, mod, src, 4'(`DISPLAY_REG)));
    endtask

    task automatic decode_digit(input display_pkg::seg_t pattern, output logic [3:0] nib);
        logic found;
        found = 1'b0;
        nib = '0;
        for (int i = 0; i < 16; i++) begin
            if (pattern === (display_pkg::HEX_SEGMENTS[i] | 8'h80)) begin
                nib = 4'(i);
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Display shows segment pattern %h, which matches no hex digit", pattern);
            end_with_failure();
        end
    endtask

    // One full rotation after settling, leftmost digit first
    task automatic read_display(output isa_pkg::word_t shown);
        logic [3:0] nib;
        display_pkg::digit_sel_t want;
        repeat ((`NUM_DIGITS + 1) * `SCAN_CYCLES) @(negedge clk_100mhz);
        shown = '0;
        for (int d = 0; d < `NUM_DIGITS; d++) begin
            want = SEL_ORDER[d];
            while (seg_sel !== want) begin
                @(negedge clk_100mhz);
            end
            decode_digit(seg_data, nib);
            shown = (shown << 4) | {12'h000, nib};
        end
    endtask

    task automatic verify_r3();
        isa_pkg::word_t shown;
        read_display(shown);
        check_word("r3 on display", model_regs[`DISPLAY_REG], shown);
    endtask

    // Rotation timing is fixed from reset release
    task automatic test_reset_display();
        check_select("seg_sel", 4'b1110, seg_sel);
        for (int d = 0; d < `NUM_DIGITS; d++) begin
            @(negedge clk_100mhz);
            check_select("seg_sel", SEL_ORDER[d], seg_sel);
            check_segments("seg_data", display_pkg::HEX_SEGMENTS[0] | 8'h80, seg_data);
            repeat (`SCAN_CYCLES - 1) @(negedge clk_100mhz);
        end
        verify_r3();
    endtask

    task automatic test_alu_ops();
        isa_pkg::reg_idx_t k;
        repeat (3) begin
            addi_reg(`DISPLAY_REG, pick_imm());
            verify_r3();
        end
        repeat (2) begin
            k = pick_reg();
            addi_reg(k, pick_imm());
            verify_r3();
            add_reg(`DISPLAY_REG, k);
            verify_r3();
            addi_reg(k, pick_imm());
            verify_r3();
            xor_reg(`DISPLAY_REG, k);
            verify_r3();
        end
        // Doubling drives r3 past 16 bits
        repeat (16) begin
            add_reg(`DISPLAY_REG, `DISPLAY_REG);
            verify_r3();
            addi_reg(`DISPLAY_REG, pick_imm());
            verify_r3();
        end
    endtask

    task automatic test_mov();
        isa_pkg::reg_idx_t k;
        isa_pkg::reg_idx_t j;
        k = pick_reg();
        j = pick_reg();
        if (j == k) begin
            j = (k == 4'd4) ? 4'd5 : 4'd4;
        end
        addi_reg(k, pick_imm());
        verify_r3();
        mov_reg(`DISPLAY_REG, k);
        verify_r3();
        addi_reg(`DISPLAY_REG, pick_imm());
        verify_r3();
        // Copy out of r3, then overwrite r3
        mov_reg(j, `DISPLAY_REG);
        verify_r3();
        addi_reg(`DISPLAY_REG, pick_imm());
        verify_r3();
        mov_reg(`DISPLAY_REG, j);
        verify_r3();
    endtask

    task automatic test_no_effect();
        isa_pkg::reg_idx_t k;
        // Nonzero index and value, so any executed op would move r3
        k = pick_reg();
        if (k == 4'd0) begin
            k = 4'd4;
        end
        addi_reg(k, pick_imm());
        send_inert(isa_pkg::R_FAMILY, 6'h3F, k);
        verify_r3();
        send_inert(isa_pkg::R_FAMILY, isa_pkg::MOD_PUSH, k);
        verify_r3();
        send_inert(isa_pkg::M_FAMILY, isa_pkg::MOD_ADD, k);
        verify_r3();
        send_inert(isa_pkg::J_FAMILY, isa_pkg::MOD_ADD, k);
        verify_r3();
        send_inert(isa_pkg::X_FAMILY, isa_pkg::MOD_ADDI, k);
        verify_r3();
    endtask

    task automatic test_stack();
        repeat (3) begin
            addi_reg(`DISPLAY_REG, pick_imm());
            verify_r3();
            push_reg(`DISPLAY_REG);
        end
        addi_reg(`DISPLAY_REG, pick_imm());
        verify_r3();
        // LIFO order
        repeat (3) begin
            pop_reg(`DISPLAY_REG);
            verify_r3();
        end
        addi_reg(`DISPLAY_REG, pick_imm());
        push_reg(`DISPLAY_REG);
        addi_reg(`DISPLAY_REG, pick_imm());
        verify_r3();
        pop_reg(4'd5);
        mov_reg(`DISPLAY_REG, 4'd5);
        verify_r3();
    endtask

    // Fill all 256 slots, then pop from sp 0 after reset
    task automatic test_stack_wrap();
        addi_reg(4'd15, pick_imm());
        for (int i = 0; i < `STACK_DEPTH; i++) begin
            push_reg(4'(i));
        end
        apply_reset();
        pop_reg(`DISPLAY_REG);
        verify_r3();
    endtask

    initial begin
        rst_n = 1'b0;
        uart_rx = 1'b1;
        apply_reset();
        test_reset_display();
        test_alu_ops();
        test_mov();
        test_no_effect();
        test_stack();
        test_stack_wrap();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* verilog/display_pkg.sv */
package display_pkg;

    // Segment pattern, active low
    // Bit 7 is the decimal point, bits 6..0 are g..a
    typedef logic [7:0] seg_t;

    // Digit select, active-low one-hot, bit 0 leftmost
    typedef logic [3:0] digit_sel_t;

    // Hex digit glyphs for a common-anode display
    // Decimal point kept off in every entry
    localparam seg_t HEX_SEGMENTS [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0,
        8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hC6, 8'hA1, 8'h86, 8'h8E
    };

endpackage

/* verilog/exec_core.sv */
`timescale 1ns/10ps
`include "uart_to_display_consts.svh"

module exec_core (
    input  logic           clk_100mhz,
    input  logic           rst_n,
    input  logic [7:0]     rx_data,
    input  logic           rx_data_valid,
    output logic           rx_data_ready,
    output isa_pkg::word_t display_word,
    stack_if.master        stack
);

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_PUSH_WAIT,
        ST_POP_WAIT
    } exec_state_t;

    exec_state_t          state;
    isa_pkg::word_t       regs [`NUM_REGS];
    logic [`STACK_AW-1:0] sp;
    logic [7:0]           high_byte;
    logic                 have_high;
    isa_pkg::reg_idx_t    pend_dst;
    isa_pkg::instr_t      instr;
    isa_pkg::word_t       src_val;
    isa_pkg::word_t       dst_val;
    isa_pkg::word_t       alu_result;
    logic                 alu_we;
    logic                 accept;
    logic                 exec_now;
    logic                 is_mem;
    logic                 issue_push;
    logic                 issue_pop;

    // Byte handshake with the receiver
    assign accept   = rx_data_valid && rx_data_ready;
    // Second byte completes the instruction
    assign exec_now = accept && have_high;

    // High byte first, low byte straight from the receiver
    assign instr   = isa_pkg::instr_t'({high_byte, rx_data});
    assign src_val = regs[instr.rr.src];
    assign dst_val = regs[instr.rr.dst];

    assign is_mem     = exec_now && (instr.rr.opcode == isa_pkg::M_FAMILY);
    assign issue_push = is_mem && (instr.rr.mod == isa_pkg::MOD_PUSH);
    assign issue_pop  = is_mem && (instr.rr.mod == isa_pkg::MOD_POP);

    // R-family ALU, wraps at 16 bits
    always_comb begin
        alu_we     = 1'b0;
        alu_result = src_val;
        if (exec_now && instr.rr.opcode == isa_pkg::R_FAMILY) begin
            case (instr.rr.mod)
                isa_pkg::MOD_MOV: begin
                    alu_we     = 1'b1;
                    alu_result = src_val;
                end
                isa_pkg::MOD_ADD: begin
                    alu_we     = 1'b1;
                    alu_result = dst_val + src_val;
                end
                isa_pkg::MOD_XOR: begin
                    alu_we     = 1'b1;
                    alu_result = dst_val ^ src_val;
                end
                isa_pkg::MOD_ADDI: begin
                    // Same bits as src, read as an immediate
                    alu_we     = 1'b1;
                    alu_result = dst_val + {12'h000, instr.ri.imm4};
                end
                default: begin
                    // Unknown mod, nothing written
                    alu_we = 1'b0;
                end
            endcase
        end
    end

    assign display_word = regs[`DISPLAY_REG];

    // Execution FSM and architectural state
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_FETCH;
            rx_data_ready <= 1'b0;
            have_high     <= 1'b0;
            sp            <= '0;
            stack.req     <= 1'b0;
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // req is a single-cycle strobe
            stack.req <= 1'b0;
            case (state)
                ST_FETCH: begin
                    // Stall the receiver while a stack op runs
                    rx_data_ready <= !(issue_push || issue_pop);
                    if (accept) begin
                        have_high <= !have_high;
                    end
                    if (alu_we) begin
                        regs[instr.rr.dst] <= alu_result;
                    end
                    if (issue_push) begin
                        // Post-increment
                        stack.req <= 1'b1;
                        sp        <= sp + 1'b1;
                        state     <= ST_PUSH_WAIT;
                    end
                    if (issue_pop) begin
                        // Pre-decrement
                        stack.req <= 1'b1;
                        sp        <= sp - 1'b1;
                        state     <= ST_POP_WAIT;
                    end
                end
                ST_PUSH_WAIT: begin
                    if (stack.done) begin
                        state <= ST_FETCH;
                    end
                end
                ST_POP_WAIT: begin
                    if (stack.done) begin
                        regs[pend_dst] <= stack.rdata;
                        state          <= ST_FETCH;
                    end
                end
                default: begin
                    state <= ST_FETCH;
                end
            endcase
        end
    end

    // Instruction byte and stack request payload
    always_ff @(posedge clk_100mhz) begin
        if (accept && !have_high) begin
            high_byte <= rx_data;
        end
        if (issue_push) begin
            stack.we    <= 1'b1;
            stack.addr  <= sp;
            stack.wdata <= dst_val;
        end
        if (issue_pop) begin
            stack.we   <= 1'b0;
            stack.addr <= sp - 1'b1;
            pend_dst   <= instr.rr.dst;
        end
    end

endmodule

/* verilog/isa_pkg.sv */
package isa_pkg;

    // Datapath word
    typedef logic [15:0] word_t;

    // Register index into the register file
    typedef logic [3:0] reg_idx_t;

    // Instruction families in the top two bits
    typedef enum logic [1:0] {
        R_FAMILY = 2'b00,
        M_FAMILY = 2'b01,
        J_FAMILY = 2'b10,
        X_FAMILY = 2'b11
    } opcode_e;

    // Modifier codes kept from the original encoding
    typedef enum logic [5:0] {
        MOD_MOV  = 6'b000000,
        MOD_ADD  = 6'b000001,
        MOD_PUSH = 6'b000010,
        MOD_POP  = 6'b000011,
        MOD_XOR  = 6'b000101,
        MOD_ADDI = 6'b010000
    } mod_e;

    // Register-register view [Op:2][Mod:6][Src:4][Dst:4]
    typedef struct packed {
        opcode_e  opcode;
        mod_e     mod;
        reg_idx_t src;
        reg_idx_t dst;
    } instr_rr_t;

    // Immediate view, src field reused as imm4
    typedef struct packed {
        opcode_e    opcode;
        mod_e       mod;
        logic [3:0] imm4;
        reg_idx_t   dst;
    } instr_ri_t;

    // One instruction word, two decodings
    typedef union packed {
        instr_rr_t rr;
        instr_ri_t ri;
    } instr_t;

endpackage

/* verilog/seg_scanner.sv */
`timescale 1ns/10ps
`include "uart_to_display_consts.svh"

module seg_scanner (
    input  logic                    clk_100mhz,
    input  logic                    rst_n,
    input  isa_pkg::word_t          display_word,
    output display_pkg::digit_sel_t seg_sel,
    output display_pkg::seg_t       seg_data
);

    localparam int TIMER_W = $clog2(`SCAN_CYCLES);
    localparam int IDX_W = $clog2(`NUM_DIGITS);
    localparam logic [TIMER_W-1:0] SCAN_LAST = TIMER_W'(`SCAN_CYCLES - 1);
    localparam logic [IDX_W-1:0] DIGIT_LAST = IDX_W'(`NUM_DIGITS - 1);

    logic [TIMER_W-1:0] scan_timer;
    logic [IDX_W-1:0]   digit_idx;
    logic [IDX_W-1:0]   next_idx;
    logic [3:0]         nibble;

    // Rotate at the end of each scan period
    always_comb begin
        next_idx = digit_idx;
        if (scan_timer == SCAN_LAST) begin
            next_idx = (digit_idx == DIGIT_LAST) ? '0 : digit_idx + 1'b1;
        end
    end

    // Leftmost digit carries the top nibble
    assign nibble = 4'(display_word >> (4 * (`NUM_DIGITS - 1 - int'(next_idx))));

    // Select and pattern registered on the same edge
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            scan_timer <= '0;
            digit_idx  <= '0;
            seg_sel    <= 4'b1110;
            seg_data   <= 8'hFF;
        end else begin
            scan_timer <= (scan_timer == SCAN_LAST) ? '0 : scan_timer + 1'b1;
            digit_idx  <= next_idx;
            seg_sel    <= ~(display_pkg::digit_sel_t'(1) << next_idx);
            // Decimal point forced off
            seg_data   <= {1'b1, display_pkg::HEX_SEGMENTS[nibble][6:0]};
        end
    end

endmodule

/* verilog/stack_if.sv */
`timescale 1ns/10ps
`include "uart_to_display_consts.svh"

interface stack_if;

    // One-cycle request strobe from the core
    logic                  req;
    // High for PUSH, low for POP
    logic                  we;
    logic [`STACK_AW-1:0]  addr;
    isa_pkg::word_t        wdata;

    // Read word, valid together with done
    isa_pkg::word_t        rdata;
    // Completion, one cycle after req
    logic                  done;

    modport master (output req, we, addr, wdata, input rdata, done);

    modport memory (input req, we, addr, wdata, output rdata, done);

endinterface

/* verilog/stack_ram.sv */
`timescale 1ns/10ps
`include "uart_to_display_consts.svh"

module stack_ram (
    input  logic    clk_100mhz,
    input  logic    rst_n,
    stack_if.memory stack
);

    // Stack storage
    isa_pkg::word_t mem [`STACK_DEPTH];

    // Single port, write or registered read per request
    always_ff @(posedge clk_100mhz) begin
        if (stack.req) begin
            if (stack.we) begin
                mem[stack.addr] <= stack.wdata;
            end else begin
                stack.rdata <= mem[stack.addr];
            end
        end
    end

    // Completion one cycle after the request
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            stack.done <= 1'b0;
        end else begin
            stack.done <= stack.req;
        end
    end

endmodule

/* verilog/uart_receiver.sv */
`timescale 1ns/10ps
`include "uart_to_display_consts.svh"

module uart_receiver (
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic       uart_rx,
    input  logic       rx_data_ready,
    output logic [7:0] rx_data,
    output logic       rx_data_valid
);

    localparam int TIMER_W = $clog2(`CLKS_PER_BIT);
    // Last count of a full bit and of half a bit
    localparam logic [TIMER_W-1:0] BIT_LAST = TIMER_W'(`CLKS_PER_BIT - 1);
    localparam logic [TIMER_W-1:0] HALF_LAST = TIMER_W'(`CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t          state;
    logic               rx_meta;
    logic               rx_sync;
    logic [TIMER_W-1:0] bit_timer;
    logic [2:0]         bit_idx;
    logic [7:0]         shift_reg;
    logic               byte_done;

    // Two-flop synchroniser, line idles high
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // Stop bit sampled high at its middle
    assign byte_done = (state == RX_STOP) && (bit_timer == BIT_LAST) && rx_sync;

    // Frame FSM, sampling at the middle of each bit
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    bit_timer <= '0;
                    bit_idx   <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (bit_timer == HALF_LAST) begin
                        bit_timer <= '0;
                        // Glitch rejection on the start bit
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_timer == BIT_LAST) begin
                        bit_timer <= '0;
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                RX_STOP: begin
                    // Framing error just drops the byte
                    if (bit_timer == BIT_LAST) begin
                        bit_timer <= '0;
                        state     <= RX_IDLE;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB first shift register
    always_ff @(posedge clk_100mhz) begin
        if (state == RX_DATA && bit_timer == BIT_LAST) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (byte_done) begin
            rx_data <= shift_reg;
        end
    end

    // Holding register handshake, newest byte overwrites
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            rx_data_valid <= 1'b0;
        end else if (byte_done) begin
            rx_data_valid <= 1'b1;
        end else if (rx_data_valid && rx_data_ready) begin
            rx_data_valid <= 1'b0;
        end
    end

endmodule

/* verilog/uart_to_display.sv */
`timescale 1ns/10ps

module uart_to_display (
    input  logic                    clk_100mhz,
    input  logic                    rst_n,
    input  logic                    uart_rx,
    output display_pkg::digit_sel_t seg_sel,
    output display_pkg::seg_t       seg_data
);

    // Receiver to core byte stream
    logic [7:0]     rx_data;
    logic           rx_data_valid;
    logic           rx_data_ready;

    // Current r3 for the display
    isa_pkg::word_t display_word;

    // Core to stack RAM
    stack_if stack_bus ();

    uart_receiver uart_receiver_inst (
        .clk_100mhz    (clk_100mhz),
        .rst_n         (rst_n),
        .uart_rx       (uart_rx),
        .rx_data_ready (rx_data_ready),
        .rx_data       (rx_data),
        .rx_data_valid (rx_data_valid)
    );

    exec_core exec_core_inst (
        .clk_100mhz    (clk_100mhz),
        .rst_n         (rst_n),
        .rx_data       (rx_data),
        .rx_data_valid (rx_data_valid),
        .rx_data_ready (rx_data_ready),
        .display_word  (display_word),
        .stack         (stack_bus.master)
    );

    stack_ram stack_ram_inst (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .stack      (stack_bus.memory)
    );

    seg_scanner seg_scanner_inst (
        .clk_100mhz   (clk_100mhz),
        .rst_n        (rst_n),
        .display_word (display_word),
        .seg_sel      (seg_sel),
        .seg_data     (seg_data)
    );

endmodule
